//--- common/align_pkg.sv
// Shared definitions for the instruction align buffer
// Parcel and word widths plus the payload types seen by the fetch unit

package align_pkg;

  // ==============================
  // Fixed widths
  // ==============================

  // One compressed instruction parcel
  localparam int PARCEL_BITS = 16;

  // One fetch word holds two parcels
  localparam int WORD_BITS = 32;

  // ==============================
  // Payload types
  // ==============================

  // Single 16-bit parcel as stored in either bank
  typedef logic [PARCEL_BITS-1:0] parcel_t;

  // Full word as delivered inside a lower-level block
  typedef logic [WORD_BITS-1:0] word_t;

  // Instruction window handed back to the fetch unit
  // Low parcel sits at the requested address
  typedef logic [WORD_BITS-1:0] inst_t;

endpackage

//--- align_buffer/tag_store.sv
// Direct-mapped tag store for the align buffer
// One tag and one valid bit per set, two asynchronous read ports
// for the even and odd lookups, a single refill write port
`timescale 1ns/1ns

module tag_store #(
  parameter  int CACHE_BITS = 512,
  parameter  int BLOCK_BITS = 128,
  parameter  int ADDR_WIDTH = 32,
  localparam int NUM_SET    = CACHE_BITS / BLOCK_BITS,
  localparam int IDX_W      = $clog2(NUM_SET),
  localparam int OFF_W      = $clog2(BLOCK_BITS / 8),
  localparam int TAG_W      = ADDR_WIDTH - IDX_W - OFF_W
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             flush_i,
  input  logic [IDX_W-1:0] rd_idx_even_i,
  input  logic [IDX_W-1:0] rd_idx_odd_i,
  input  logic             wr_en_i,
  input  logic [IDX_W-1:0] wr_idx_i,
  input  logic [TAG_W-1:0] wr_tag_i,
  output logic             rd_valid_even_o,
  output logic [TAG_W-1:0] rd_tag_even_o,
  output logic             rd_valid_odd_o,
  output logic [TAG_W-1:0] rd_tag_odd_o
);

  // Valid bit per set
  logic [NUM_SET-1:0] valid_q;

  // Tag array
  logic [TAG_W-1:0] tag_q [NUM_SET];

  // Flush wins over a refill in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[wr_idx_i] <= 1'b1;
    end
  end

  // Tag bits only matter once the valid bit is set
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_q[wr_idx_i] <= wr_tag_i;
    end
  end

  // ==============================
  // Lookup ports
  // ==============================

  // Even port sees the next set on an unaligned window
  assign rd_valid_even_o = valid_q[rd_idx_even_i];
  assign rd_tag_even_o   = tag_q[rd_idx_even_i];

  // Odd port always sees the addressed set
  assign rd_valid_odd_o = valid_q[rd_idx_odd_i];
  assign rd_tag_odd_o   = tag_q[rd_idx_odd_i];

endmodule

//--- align_buffer/parcel_bank.sv
// One parcel bank of the align buffer
// Keeps one parcel per word of each block, filled a whole row at a time
// on refill and read one parcel at a time by word select
`timescale 1ns/1ns

module parcel_bank #(
  parameter  int CACHE_BITS  = 512,
  parameter  int BLOCK_BITS  = 128,
  localparam int NUM_SET     = CACHE_BITS / BLOCK_BITS,
  localparam int IDX_W       = $clog2(NUM_SET),
  localparam int ROW_PARCELS = BLOCK_BITS / align_pkg::WORD_BITS,
  localparam int WSEL_W      = $clog2(ROW_PARCELS)
) (
  input  logic                                clk_i,
  input  logic                                wr_en_i,
  input  logic [IDX_W-1:0]                    wr_idx_i,
  input  align_pkg::parcel_t [ROW_PARCELS-1:0] wr_row_i,
  input  logic [IDX_W-1:0]                    rd_idx_i,
  input  logic [WSEL_W-1:0]                   word_sel_i,
  output align_pkg::parcel_t                  rd_parcel_o
);

  import align_pkg::*;

  // ==============================
  // Storage
  // ==============================

  // One row per set, one parcel per word in the block
  parcel_t [ROW_PARCELS-1:0] rows_q [NUM_SET];

  // Refill replaces the whole row
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      rows_q[wr_idx_i] <= wr_row_i;
    end
  end

  // ==============================
  // Read port
  // ==============================

  // Asynchronous read so a double hit completes in the request cycle
  assign rd_parcel_o = rows_q[rd_idx_i][word_sel_i];

endmodule

//--- align_buffer/miss_sequencer.sv
// Miss sequencer for the align buffer
// Classifies both banks as hit or miss, issues lower-level block fetches,
// drives refill writes and walks a double miss through two fetches
`timescale 1ns/1ns

module miss_sequencer #(
  parameter  int CACHE_BITS = 512,
  parameter  int BLOCK_BITS = 128,
  parameter  int ADDR_WIDTH = 32,
  localparam int NUM_SET    = CACHE_BITS / BLOCK_BITS,
  localparam int IDX_W      = $clog2(NUM_SET),
  localparam int OFF_W      = $clog2(BLOCK_BITS / 8),
  localparam int TAG_W      = ADDR_WIDTH - IDX_W - OFF_W
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  logic                  req_valid_i,
  input  logic [ADDR_WIDTH-1:0] req_addr_i,
  input  logic                  low_res_valid_i,
  input  logic                  rd_valid_even_i,
  input  logic [TAG_W-1:0]      rd_tag_even_i,
  input  logic                  rd_valid_odd_i,
  input  logic [TAG_W-1:0]      rd_tag_odd_i,
  output logic [IDX_W-1:0]      rd_idx_even_o,
  output logic [IDX_W-1:0]      rd_idx_odd_o,
  output logic                  tag_wr_en_o,
  output logic [IDX_W-1:0]      tag_wr_idx_o,
  output logic [TAG_W-1:0]      tag_wr_tag_o,
  output logic                  bank_wr_en_o,
  output logic [IDX_W-1:0]      even_wr_idx_o,
  output logic [IDX_W-1:0]      odd_wr_idx_o,
  output logic [1:0]            miss_state_o,
  output logic                  masked_valid_o,
  output logic                  second_done_o,
  output logic                  low_req_valid_o,
  output logic [ADDR_WIDTH-1:0] low_req_addr_o
);

  import align_pkg::*;

  localparam int PAR_OFF = $clog2(PARCEL_BITS / 8);
  localparam logic [ADDR_WIDTH-1:0] BLOCK_BYTES = ADDR_WIDTH'(BLOCK_BITS / 8);

  logic                  unalign;
  logic                  wrap;
  logic [TAG_W-1:0]      tag_odd;
  logic [TAG_W-1:0]      tag_even;
  logic                  even_miss;
  logic                  odd_miss;
  logic                  first_resp;
  logic [IDX_W-1:0]      refill_idx;
  logic [ADDR_WIDTH-1:0] base_addr;
  logic                  ignore_valid_q;
  logic                  waiting_second_q;

  // ==============================
  // Lookup and classification
  // ==============================
  always_comb begin
    // Window starts at the last parcel of the block
    unalign = &req_addr_i[OFF_W-1:PAR_OFF];

    // Odd bank always sits in the addressed block
    rd_idx_odd_o = req_addr_i[OFF_W +: IDX_W];
    {wrap, rd_idx_even_o} = {1'b0, rd_idx_odd_o} + {{IDX_W{1'b0}}, unalign};

    // Next block past the top set belongs to the next tag
    tag_odd  = req_addr_i[ADDR_WIDTH-1 -: TAG_W];
    tag_even = wrap ? tag_odd + 1'b1 : tag_odd;

    even_miss = req_valid_i && !(rd_valid_even_i && (rd_tag_even_i == tag_even));
    odd_miss  = req_valid_i && !(rd_valid_odd_i && (rd_tag_odd_i == tag_odd));
    miss_state_o = {odd_miss, even_miss};
  end

  // ==============================
  // Double-miss sequencing
  // ==============================

  // Response is hidden in the cycle after the first half of a double miss
  assign masked_valid_o = low_res_valid_i && !ignore_valid_q;

  // First of two responses for a straddling window
  assign first_resp = unalign && odd_miss && even_miss && masked_valid_o;

  assign second_done_o = waiting_second_q && masked_valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      ignore_valid_q   <= 1'b0;
      waiting_second_q <= 1'b0;
    end else begin
      ignore_valid_q <= first_resp;
      if (first_resp) begin
        waiting_second_q <= 1'b1;
      end else if (second_done_o) begin
        waiting_second_q <= 1'b0;
      end
    end
  end

  // ==============================
  // Lower-level request
  // ==============================
  always_comb begin
    base_addr = {req_addr_i[ADDR_WIDTH-1:OFF_W], {OFF_W{1'b0}}};

    // Held until the response pulse, dropped in that cycle
    if (waiting_second_q) begin
      low_req_valid_o = !masked_valid_o;
    end else begin
      low_req_valid_o = (odd_miss || even_miss) && !masked_valid_o;
    end

    // Only the next block is missing, or the second fetch of a double miss
    if (waiting_second_q || (unalign && even_miss && !odd_miss)) begin
      low_req_addr_o = base_addr + BLOCK_BYTES;
    end else begin
      low_req_addr_o = base_addr;
    end
  end

  // ==============================
  // Refill writes
  // ==============================
  always_comb begin
    // Odd line is filled first when both are missing
    refill_idx   = odd_miss ? rd_idx_odd_o : rd_idx_even_o;
    tag_wr_tag_o = odd_miss ? tag_odd : tag_even;
    tag_wr_idx_o = refill_idx;
    tag_wr_en_o  = masked_valid_o && (odd_miss || even_miss);

    // A block spans both banks, so both rows land in the same set
    bank_wr_en_o  = tag_wr_en_o;
    even_wr_idx_o = refill_idx;
    odd_wr_idx_o  = refill_idx;
  end

endmodule

//--- align_buffer/inst_assembler.sv
// Instruction assembler for the align buffer
// Picks each parcel from its bank or from the lower-level response
// and orders them by the half-word offset of the request
`timescale 1ns/1ns

module inst_assembler #(
  parameter  int BLOCK_BITS  = 128,
  parameter  int ADDR_WIDTH  = 32,
  localparam int ROW_PARCELS = BLOCK_BITS / align_pkg::WORD_BITS,
  localparam int WSEL_W      = $clog2(ROW_PARCELS),
  localparam int OFF_W       = $clog2(BLOCK_BITS / 8)
) (
  input  logic                  req_valid_i,
  input  logic [ADDR_WIDTH-1:0] req_addr_i,
  input  logic [1:0]            miss_state_i,
  input  logic                  masked_valid_i,
  input  logic                  second_done_i,
  input  align_pkg::parcel_t    even_parcel_i,
  input  align_pkg::parcel_t    odd_parcel_i,
  input  logic [BLOCK_BITS-1:0] low_res_blk_i,
  output logic                  res_valid_o,
  output align_pkg::inst_t      res_inst_o,
  output logic                  res_miss_o
);

  import align_pkg::*;

  localparam int WORD_OFF = $clog2(WORD_BITS / 8);

  logic              half_sel;
  logic              unalign;
  logic              even_miss;
  logic              odd_miss;
  logic              single_ok;
  logic [WSEL_W-1:0] word_sel;
  logic [WSEL_W-1:0] next_sel;
  word_t             cur_word;
  word_t             next_word;
  parcel_t           even_pick;
  parcel_t           odd_pick;

  // ==============================
  // Parcel selection
  // ==============================
  always_comb begin
    half_sel = req_addr_i[WORD_OFF-1];
    word_sel = req_addr_i[OFF_W-1:WORD_OFF];
    unalign  = half_sel && (&word_sel);

    // Word holding the even parcel, wraps to word 0 of the new line
    next_sel = word_sel + WSEL_W'(half_sel);
    {odd_miss, even_miss} = miss_state_i;

    // Response words, only meaningful in a response cycle
    cur_word  = low_res_blk_i[word_sel*WORD_BITS +: WORD_BITS];
    next_word = low_res_blk_i[next_sel*WORD_BITS +: WORD_BITS];

    // Missing parcels come straight from the response
    // On double-miss completion the even parcel is the first one of the new line
    even_pick = even_miss ? next_word[PARCEL_BITS-1:0] : even_parcel_i;
    odd_pick  = odd_miss ? cur_word[WORD_BITS-1 -: PARCEL_BITS] : odd_parcel_i;
  end

  // ==============================
  // Instruction and status
  // ==============================
  always_comb begin
    // Aligned window is odd over even, half offset swaps them
    if (half_sel) begin
      res_inst_o = {even_pick, odd_pick};
    end else begin
      res_inst_o = {odd_pick, even_pick};
    end

    // One response is enough unless both lines of a straddle are absent
    single_ok = masked_valid_i && (|miss_state_i) && !(unalign && (&miss_state_i));

    res_valid_o = (req_valid_i && (miss_state_i == 2'b00)) || single_ok || second_done_i;
    res_miss_o  = |miss_state_i;
  end

endmodule

//--- align_buffer/align_buffer.sv
// Instruction align buffer for a fetch unit with compressed instructions
// Caches blocks as an even and an odd parcel bank, returns a 32-bit window
// for any half-word address, including windows that cross a block boundary
`timescale 1ns/1ns

module align_buffer #(
  parameter int CACHE_BITS = 512,
  parameter int BLOCK_BITS = 128,
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  logic                  req_valid_i,
  input  logic [ADDR_WIDTH-1:0] req_addr_i,
  output logic                  res_valid_o,
  output align_pkg::inst_t      res_inst_o,
  output logic                  res_miss_o,
  output logic                  low_req_valid_o,
  output logic [ADDR_WIDTH-1:0] low_req_addr_o,
  input  logic                  low_res_valid_i,
  input  logic [BLOCK_BITS-1:0] low_res_blk_i
);

  import align_pkg::*;

  localparam int NUM_SET     = CACHE_BITS / BLOCK_BITS;
  localparam int IDX_W       = $clog2(NUM_SET);
  localparam int OFF_W       = $clog2(BLOCK_BITS / 8);
  localparam int TAG_W       = ADDR_WIDTH - IDX_W - OFF_W;
  localparam int ROW_PARCELS = BLOCK_BITS / WORD_BITS;
  localparam int WSEL_W      = $clog2(ROW_PARCELS);
  localparam int WORD_OFF    = $clog2(WORD_BITS / 8);

  // Tag lookup
  logic [IDX_W-1:0] idx_even;
  logic [IDX_W-1:0] idx_odd;
  logic             valid_even;
  logic             valid_odd;
  logic [TAG_W-1:0] tag_even;
  logic [TAG_W-1:0] tag_odd;

  // Refill controls
  logic             tag_wr_en;
  logic [IDX_W-1:0] tag_wr_idx;
  logic [TAG_W-1:0] tag_wr_tag;
  logic             bank_wr_en;
  logic [IDX_W-1:0] even_wr_idx;
  logic [IDX_W-1:0] odd_wr_idx;

  // Sequencer status toward the assembler
  logic [1:0] miss_state;
  logic       masked_valid;
  logic       second_done;

  // Bank data
  parcel_t [ROW_PARCELS-1:0] even_row;
  parcel_t [ROW_PARCELS-1:0] odd_row;
  parcel_t                   even_parcel;
  parcel_t                   odd_parcel;
  logic [WSEL_W-1:0]         odd_word_sel;
  logic [WSEL_W-1:0]         even_word_sel;

  // ==============================
  // Bank word selects
  // ==============================

  // Odd bank reads the high parcel of the addressed word
  assign odd_word_sel = req_addr_i[OFF_W-1:WORD_OFF];

  // Even bank reads the next word on a half offset
  // Sum wraps to word 0 when the window is unaligned
  assign even_word_sel = odd_word_sel + WSEL_W'(req_addr_i[WORD_OFF-1]);

  // Split the refill block into low and high parcel rows
  for (genvar i = 0; i < ROW_PARCELS; i++) begin : g_row_split
    assign even_row[i] = low_res_blk_i[i*WORD_BITS +: PARCEL_BITS];
    assign odd_row[i]  = low_res_blk_i[i*WORD_BITS+PARCEL_BITS +: PARCEL_BITS];
  end

  // ==============================
  // Storage
  // ==============================

  tag_store #(
    .CACHE_BITS(CACHE_BITS),
    .BLOCK_BITS(BLOCK_BITS),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_tag_store (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .rd_idx_even_i  (idx_even),
    .rd_idx_odd_i   (idx_odd),
    .wr_en_i        (tag_wr_en),
    .wr_idx_i       (tag_wr_idx),
    .wr_tag_i       (tag_wr_tag),
    .rd_valid_even_o(valid_even),
    .rd_tag_even_o  (tag_even),
    .rd_valid_odd_o (valid_odd),
    .rd_tag_odd_o   (tag_odd)
  );

  // Low halves of every word
  parcel_bank #(
    .CACHE_BITS(CACHE_BITS),
    .BLOCK_BITS(BLOCK_BITS)
  ) u_even_bank (
    .clk_i      (clk_i),
    .wr_en_i    (bank_wr_en),
    .wr_idx_i   (even_wr_idx),
    .wr_row_i   (even_row),
    .rd_idx_i   (idx_even),
    .word_sel_i (even_word_sel),
    .rd_parcel_o(even_parcel)
  );

  // High halves of every word
  parcel_bank #(
    .CACHE_BITS(CACHE_BITS),
    .BLOCK_BITS(BLOCK_BITS)
  ) u_odd_bank (
    .clk_i      (clk_i),
    .wr_en_i    (bank_wr_en),
    .wr_idx_i   (odd_wr_idx),
    .wr_row_i   (odd_row),
    .rd_idx_i   (idx_odd),
    .word_sel_i (odd_word_sel),
    .rd_parcel_o(odd_parcel)
  );

  // ==============================
  // Control and output
  // ==============================

  miss_sequencer #(
    .CACHE_BITS(CACHE_BITS),
    .BLOCK_BITS(BLOCK_BITS),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_miss_sequencer (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .low_res_valid_i(low_res_valid_i),
    .rd_valid_even_i(valid_even),
    .rd_tag_even_i  (tag_even),
    .rd_valid_odd_i (valid_odd),
    .rd_tag_odd_i   (tag_odd),
    .rd_idx_even_o  (idx_even),
    .rd_idx_odd_o   (idx_odd),
    .tag_wr_en_o    (tag_wr_en),
    .tag_wr_idx_o   (tag_wr_idx),
    .tag_wr_tag_o   (tag_wr_tag),
    .bank_wr_en_o   (bank_wr_en),
    .even_wr_idx_o  (even_wr_idx),
    .odd_wr_idx_o   (odd_wr_idx),
    .miss_state_o   (miss_state),
    .masked_valid_o (masked_valid),
    .second_done_o  (second_done),
    .low_req_valid_o(low_req_valid_o),
    .low_req_addr_o (low_req_addr_o)
  );

  inst_assembler #(
    .BLOCK_BITS(BLOCK_BITS),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_inst_assembler (
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .miss_state_i  (miss_state),
    .masked_valid_i(masked_valid),
    .second_done_i (second_done),
    .even_parcel_i (even_parcel),
    .odd_parcel_i  (odd_parcel),
    .low_res_blk_i (low_res_blk_i),
    .res_valid_o   (res_valid_o),
    .res_inst_o    (res_inst_o),
    .res_miss_o    (res_miss_o)
  );

endmodule

//--- sim/align_checker.sv
// Result checker for the align buffer testbench
// Watches the fetch and lower-level ports, compares each response with the
// expected instruction and miss flag, checks hit timing and refill requests
`timescale 1ns/1ns

module align_checker #(
  parameter int BLOCK_BYTES = 16
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_valid_i,
  input  logic [31:0] req_addr_i,
  input  logic        res_valid_i,
  input  logic [31:0] res_inst_i,
  input  logic        res_miss_i,
  input  logic        low_req_valid_i,
  input  logic [31:0] low_req_addr_i,
  input  logic        low_res_valid_i,
  input  logic [31:0] exp_inst_i,
  input  logic        exp_miss_i,
  input  int          test_num_i,
  output int          pass_cnt_o,
  output int          fail_cnt_o
);

  localparam logic [31:0] OFF_MASK = 32'(BLOCK_BYTES - 1);

  // Cycles the current request has waited
  int          wait_cycles;
  // Lower requests issued for the current fetch
  int          low_reqs;
  logic        low_req_q;
  logic        ok;
  logic [31:0] blk_base;
  logic [31:0] prev_req_addr;
  logic        last_parcel;

  // Addressed block and whether the window runs into the next one
  assign blk_base    = req_addr_i & ~OFF_MASK;
  assign last_parcel = (req_addr_i & OFF_MASK) == OFF_MASK - 32'd1;

  // Sampled mid-cycle where the combinational outputs are settled
  always @(negedge clk_i) begin
    if (rst_i) begin
      wait_cycles = 0;
      low_reqs    = 0;
      ok          = 1'b1;
      pass_cnt_o  = 0;
      fail_cnt_o  = 0;
    end else if (req_valid_i) begin
      // New lower request fetches the addressed block or the next one
      if (low_req_valid_i && !low_req_q) begin
        low_reqs = low_reqs + 1;
        if (low_req_addr_i != blk_base &&
            !(last_parcel && low_req_addr_i == blk_base + BLOCK_BYTES)) begin
          $display("CHECK FAILED at %0t: test %0d lower request to %h for addr %h",
                   $time, test_num_i, low_req_addr_i, req_addr_i);
          ok = 1'b0;
        end
        // Second fetch of a straddle goes to the following block
        if (low_reqs > 2 ||
            (low_reqs == 2 && low_req_addr_i != prev_req_addr + BLOCK_BYTES)) begin
          $display("CHECK FAILED at %0t: test %0d lower request %0d to %h out of order",
                   $time, test_num_i, low_reqs, low_req_addr_i);
          ok = 1'b0;
        end
        prev_req_addr = low_req_addr_i;
      end
      // Request stays up until the response pulse and drops with it
      if (low_res_valid_i && low_req_valid_i) begin
        $display("CHECK FAILED at %0t: test %0d lower request still high in the response cycle",
                 $time, test_num_i);
        ok = 1'b0;
      end
      if (!low_res_valid_i && !res_valid_i && !low_req_valid_i) begin
        $display("CHECK FAILED at %0t: test %0d lower request dropped before the response",
                 $time, test_num_i);
        ok = 1'b0;
      end
      if (res_valid_i) begin
        if (res_inst_i !== exp_inst_i || res_miss_i !== exp_miss_i) begin
          $display("CHECK FAILED at %0t: test %0d addr %h got inst %h miss %0b, exp %h miss %0b",
                   $time, test_num_i, req_addr_i, res_inst_i, res_miss_i,
                   exp_inst_i, exp_miss_i);
          ok = 1'b0;
        end
        // A hit has to complete in the request cycle
        if (!exp_miss_i && (wait_cycles != 0 || low_reqs != 0)) begin
          $display("CHECK FAILED at %0t: test %0d hit took %0d extra cycles and %0d fetches",
                   $time, test_num_i, wait_cycles, low_reqs);
          ok = 1'b0;
        end
        // Miss answers in the cycle of the refilling response
        if (exp_miss_i && (low_reqs == 0 || !low_res_valid_i)) begin
          $display("CHECK FAILED at %0t: test %0d miss answered outside a lower response",
                   $time, test_num_i);
          ok = 1'b0;
        end
        if (ok) begin
          pass_cnt_o = pass_cnt_o + 1;
          $display("test %0d: addr %h inst %h miss %0b ok (%0d wait cycles)",
                   test_num_i, req_addr_i, res_inst_i, res_miss_i, wait_cycles);
        end else begin
          fail_cnt_o = fail_cnt_o + 1;
        end
        wait_cycles = 0;
        low_reqs    = 0;
        ok          = 1'b1;
      end else begin
        wait_cycles = wait_cycles + 1;
      end
    end else if (res_valid_i || low_req_valid_i) begin
      $display("DUT output active at %0t without any request pending", $time);
      fail_cnt_o = fail_cnt_o + 1;
    end
    low_req_q = low_req_valid_i;
  end

endmodule

//--- sim/tb_align_buffer.sv
// Testbench for the instruction align buffer
// Reads fetch and flush tests from the vector file, models the lower
// memory with random response latency and hands results to the checker
`timescale 1ns/1ns

module tb_align_buffer;

  import align_pkg::*;

  localparam int CACHE_BITS = 512;
  localparam int BLOCK_BITS = 128;
  localparam int ADDR_WIDTH = 32;
  localparam int MAX_VEC    = 64;

  logic                  clk_i;
  logic                  rst_i;
  logic                  flush_i;
  logic                  req_valid_i;
  logic [ADDR_WIDTH-1:0] req_addr_i;
  logic                  res_valid_o;
  inst_t                 res_inst_o;
  logic                  res_miss_o;
  logic                  low_req_valid_o;
  logic [ADDR_WIDTH-1:0] low_req_addr_o;
  logic                  low_res_valid_i;
  logic [BLOCK_BITS-1:0] low_res_blk_i;

  // Expected values handed to the checker
  inst_t exp_inst;
  logic  exp_miss;
  int    test_num;
  int    pass_cnt;
  int    fail_cnt;

  // Vector storage
  logic [7:0]            vec_op   [MAX_VEC];
  logic [ADDR_WIDTH-1:0] vec_addr [MAX_VEC];
  logic [31:0]           vec_inst [MAX_VEC];
  logic                  vec_miss [MAX_VEC];
  int                    num_vec;
  int                    num_fetch;
  logic                  loaded;
  logic [31:0]           rng_state;

  align_buffer #(
    .CACHE_BITS(CACHE_BITS),
    .BLOCK_BITS(BLOCK_BITS),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) UUT (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .res_valid_o    (res_valid_o),
    .res_inst_o     (res_inst_o),
    .res_miss_o     (res_miss_o),
    .low_req_valid_o(low_req_valid_o),
    .low_req_addr_o (low_req_addr_o),
    .low_res_valid_i(low_res_valid_i),
    .low_res_blk_i  (low_res_blk_i)
  );

  align_checker #(
    .BLOCK_BYTES(BLOCK_BITS / 8)
  ) u_checker (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .res_valid_i    (res_valid_o),
    .res_inst_i     (res_inst_o),
    .res_miss_i     (res_miss_o),
    .low_req_valid_i(low_req_valid_o),
    .low_req_addr_i (low_req_addr_o),
    .low_res_valid_i(low_res_valid_i),
    .exp_inst_i     (exp_inst),
    .exp_miss_i     (exp_miss),
    .test_num_i     (test_num),
    .pass_cnt_o     (pass_cnt),
    .fail_cnt_o     (fail_cnt)
  );

  // ==============================
  // Clock and memory rule
  // ==============================
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Parcel at byte address a is half-word number a/2 xor a constant
  function automatic logic [BLOCK_BITS-1:0] mem_block(input logic [ADDR_WIDTH-1:0] base);
    logic [BLOCK_BITS-1:0] blk;
    logic [ADDR_WIDTH-1:0] hw;
    for (int i = 0; i < BLOCK_BITS / PARCEL_BITS; i++) begin
      hw = (base >> 1) + ADDR_WIDTH'(i);
      blk[i*PARCEL_BITS +: PARCEL_BITS] = hw[15:0] ^ 16'hA5C3;
    end
    return blk;
  endfunction

  // Lower memory answers one request at a time after 1 to 4 cycles
  initial begin : lower_memory
    logic [ADDR_WIDTH-1:0] addr;
    int                    lat;
    rng_state = 32'd24730;
    @(negedge rst_i);
    forever begin
      @(negedge clk_i);
      if (low_req_valid_o) begin
        addr      = low_req_addr_o;
        rng_state = xorshift32(rng_state);
        lat       = int'(rng_state % 4) + 1;
        repeat (lat) @(posedge clk_i);
        #1;
        low_res_valid_i = 1'b1;
        low_res_blk_i   = mem_block(addr);
        @(posedge clk_i);
        #1;
        low_res_valid_i = 1'b0;
      end
    end
  end

  // ==============================
  // Vector reader
  // ==============================
  task automatic read_vectors();
    int    fd;
    int    got;
    string line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] e;
    logic [31:0] m;
    num_vec   = 0;
    num_fetch = 0;
    fd = $fopen("sim/align_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file sim/align_vectors.txt");
    end else begin
      while (!$feof(fd) && num_vec < MAX_VEC) begin
        got = $fgets(line, fd);
        // Skip comment and empty lines
        if (got > 1 && line.substr(0, 1) != "//") begin
          got = $sscanf(line, "%c %h %h %h", op, a, e, m);
          if (got == 4) begin
            vec_op[num_vec]   = op;
            vec_addr[num_vec] = a;
            vec_inst[num_vec] = e;
            vec_miss[num_vec] = m[0];
            if (op == "F") begin
              num_fetch++;
            end
            num_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ==============================
  // Stimulus
  // ==============================
  task automatic run_fetch(input int n);
    @(posedge clk_i);
    #1;
    test_num    = n;
    exp_inst    = vec_inst[n];
    exp_miss    = vec_miss[n];
    req_addr_i  = vec_addr[n];
    req_valid_i = 1'b1;
    // Hold the request until the buffer answers
    do begin
      @(negedge clk_i);
    end while (!res_valid_o);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic run_flush(input int n);
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    $display("test %0d: flush done", n);
  endtask

  // Watchdog sized from the number of tests
  initial begin
    wait (loaded);
    repeat ((num_vec + 1) * 40) @(posedge clk_i);
    $display("The run timed out before all tests finished");
    $display("Regression failed");
    $finish;
  end

  initial begin
    rst_i           = 1'b1;
    flush_i         = 1'b0;
    req_valid_i     = 1'b0;
    req_addr_i      = '0;
    low_res_valid_i = 1'b0;
    low_res_blk_i   = '0;
    exp_inst        = '0;
    exp_miss        = 1'b0;
    test_num        = 0;
    loaded          = 1'b0;
    read_vectors();
    loaded = 1'b1;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    for (int n = 0; n < num_vec; n++) begin
      if (vec_op[n] == "X") begin
        run_flush(n);
      end else begin
        run_fetch(n);
      end
    end
    repeat (2) @(posedge clk_i);
    $display("Summary: %0d passed, %0d failed, %0d fetch tests", pass_cnt, fail_cnt, num_fetch);
    if (fail_cnt == 0 && pass_cnt == num_fetch && num_fetch > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sim/align_vectors.txt
// op addr inst miss : F fetch with expected instruction and miss flag, X flush
// Parcel at byte address a is (a/2) xor A5C3, the window is {parcel a+2, parcel a}
F 00000000 A5C2A5C3 1
F 00000000 A5C2A5C3 0
F 00000004 A5C0A5C1 0
F 00000002 A5C1A5C2 0
F 0000000A A5C5A5C6 0
F 0000000E A5CBA5C4 1
F 00000010 A5CAA5CB 0
F 00000026 A5D7A5D0 1
F 00000024 A5D0A5D1 0
F 0000002E A5DBA5D4 1
F 0000004E A5EBA5E4 1
F 0000004E A5EBA5E4 0
F 00000050 A5EAA5EB 0
F 0000007E A583A5FC 1
F 0000007E A583A5FC 0
F 00000080 A582A583 0
F 00000000 A5C2A5C3 1
F 0000007E A583A5FC 1
F 00000080 A582A583 0
X 00000000 00000000 0
F 00000080 A582A583 1
F 00000004 A5C0A5C1 1
F 00000004 A5C0A5C1 0
X 00000000 00000000 0
F 00000004 A5C0A5C1 1
F 0000000C A5C4A5C5 0
F 00000006 A5C7A5C0 0

//--- files.f
common/align_pkg.sv
align_buffer/tag_store.sv
align_buffer/parcel_bank.sv
align_buffer/miss_sequencer.sv
align_buffer/inst_assembler.sv
align_buffer/align_buffer.sv
sim/align_checker.sv
sim/tb_align_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the align buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f files.f \
  --top-module tb_align_buffer -Mdir obj_dir -o sim_align_buffer \
  && ./obj_dir/sim_align_buffer > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"

grep -q "Regression failed" "$LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q "Regression passed" "$LOG" || { echo "No result found in log"; exit 1; }
exit 0
